/* build.f */
+incdir+hdl
hdl/vcs_pkg.sv
hdl/vcs_host_loader.sv
hdl/vcs_bus_ctrl.sv
hdl/vcs_cart_rom.sv
hdl/vcs_ram.sv
hdl/vcs_mem_top.sv
verification/vcs_mem_properties.sv
verification/vcs_mem_tb.sv

/* Bender.yml */
package:
  name: vcs_mem

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vcs_pkg.sv
      - hdl/vcs_host_loader.sv
      - hdl/vcs_bus_ctrl.sv
      - hdl/vcs_cart_rom.sv
      - hdl/vcs_ram.sv
      - hdl/vcs_mem_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/vcs_mem_properties.sv
      - verification/vcs_mem_tb.sv

/* verification/vcs_mem_tb.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_mem_tb import vcs_pkg::*; ();

  localparam int         CLK_HALF       = 20;                          // 40 ns period
  localparam int         TIMEOUT_CYCLES = 2 * (4096 + 8192 + 16384 + 32768); // All loads x2
  localparam logic [7:0] TIA_BYTE       = 8'h5A;
  localparam logic [7:0] PIA_BYTE       = 8'hA5;
  localparam cpu_bus_t   IDLE_BUS       = '{addr: 16'h0000, wdata: 8'h00, rnw: 1'b1};

  logic       clk_sys;
  logic       pwr_up_reset_n;   // Active high despite the name
  cpu_bus_t   cpu;
  host_req_t  host;
  logic [7:0] tia_dat;
  logic [7:0] pia_dat;
  logic [7:0] cpu_din;
  logic [7:0] host_rdata;
  logic       tia_cs;
  logic       pia_cs;
  logic       cpu_enable;
  logic       tia_enable;
  logic       cpu_reset;
  logic       cpu_rdy;
  logic       pal;

  logic [7:0] rom_model  [1 << `VCS_ROM_AW];   // What the host loaded
  logic [7:0] ram_model  [1 << `VCS_RAM_AW];
  logic [7:0] cart_model [1 << `VCS_RAM_AW];
  integer     seed = 32;
  int         err_count = 0;
  int         check_count = 0;
  int         cycles = 0;
  int         prop_fails;

  vcs_mem_top vcs_mem_top_i (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cpu_i          (cpu),
    .host_i         (host),
    .tia_dat_i      (tia_dat),
    .pia_dat_i      (pia_dat),
    .cpu_din_o      (cpu_din),
    .host_rdata_o   (host_rdata),
    .tia_cs_o       (tia_cs),
    .pia_cs_o       (pia_cs),
    .cpu_enable_o   (cpu_enable),
    .tia_enable_o   (tia_enable),
    .cpu_reset_o    (cpu_reset),
    .cpu_rdy_o      (cpu_rdy),
    .pal_o          (pal)
  );

  initial clk_sys = 1'b0;
  always #CLK_HALF clk_sys = ~clk_sys;

  always @(posedge clk_sys) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests still running after %0d cycles", cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR @%0t ns: %s got %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR @%0t ns: %s got %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Scheme from the loader plus the control-driven level outputs
  task automatic check_scheme_pal(input bank_scheme_e exp_scheme, input cart_ctrl_t exp_ctrl,
                                  input string what);
    bank_scheme_e got_scheme;
    got_scheme = vcs_mem_top_i.scheme;
    check_count++;
    if (got_scheme !== exp_scheme) begin
      err_count++;
      $display("ERR @%0t ns: %s scheme %s, expected %s", $time, what,
               got_scheme.name(), exp_scheme.name());
    end
    check_bit(pal, exp_ctrl.pal, {what, " pal_o"});
    check_bit(cpu_rdy, !exp_ctrl.load_hold, {what, " cpu_rdy_o"});
    check_bit(cpu_reset, exp_ctrl.soft_reset, {what, " cpu_reset_o"});   // Power-up reset low
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %-12s %s, %0d errors", name,
             (err_count == errs_before) ? "done" : "failed", err_count - errs_before);
  endtask

  // ==============================
  // Bus drivers
  // ==============================
  function automatic logic [7:0] pattern_byte(input logic [14:0] off);
    return off[7:0] ^ {off[14:8], 1'b1};   // Differs per bank and offset
  endfunction

  task automatic cpu_drive(input logic [15:0] addr, input logic [7:0] wdata, input logic rnw);
    @(posedge clk_sys);
    cpu <= '{addr: addr, wdata: wdata, rnw: rnw};
  endtask

  task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
    cpu_drive(addr, data, 1'b0);
    @(posedge clk_sys);
    cpu <= IDLE_BUS;   // Write lands on this edge
  endtask

  // Data is valid one cycle after the address, sampled mid-cycle
  task automatic cpu_read(input logic [15:0] addr, output logic [7:0] data);
    cpu_drive(addr, 8'h00, 1'b1);
    @(posedge clk_sys);
    @(negedge clk_sys);
    data = cpu_din;
  endtask

  task automatic cpu_read_check(input logic [15:0] addr, input logic [7:0] exp, input string what);
    logic [7:0] data;
    cpu_read(addr, data);
    check_byte(data, exp, $sformatf("%s at %04h", what, addr));
  endtask

  task automatic hold_hotspot(input logic [15:0] addr);
    cpu_drive(addr, 8'h00, 1'b1);
    repeat (16) @(posedge clk_sys);   // Spans one bank sampling phase
    cpu <= IDLE_BUS;
  endtask

  task automatic load_image(input int size, input logic random_fill);
    for (int off = 0; off < size; off++) begin
      if (random_fill) rom_model[off] = 8'($random(seed));
      else             rom_model[off] = pattern_byte(15'(off));
      @(posedge clk_sys);
      host <= '{wr: 1'b1, rd: 1'b0, addr: {`VCS_REGION_ROM, 9'h000, 15'(off)},
                wdata: rom_model[off]};
    end
    @(posedge clk_sys);
    host <= '0;
    @(negedge clk_sys);   // Size register settled
  endtask

  task automatic host_ram_read(input logic [6:0] addr, output logic [7:0] data);
    @(posedge clk_sys);
    host <= '{wr: 1'b0, rd: 1'b1, addr: {`VCS_REGION_ROM, 17'h0, addr}, wdata: 8'h00};
    @(posedge clk_sys);
    @(negedge clk_sys);
    data = host_rdata;
    @(posedge clk_sys);
    host <= '0;
  endtask

  task automatic ctrl_write(input cart_ctrl_t value);
    @(posedge clk_sys);
    host <= '{wr: 1'b1, rd: 1'b0, addr: {`VCS_REGION_CTRL, 24'h0}, wdata: {4'h0, value}};
    @(posedge clk_sys);
    host <= '0;
    @(negedge clk_sys);
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_phases();
    logic [3:0] ph;
    int         errs0;
    errs0 = err_count;
    for (int i = 0; i < 32; i++) begin
      @(negedge clk_sys);
      ph = 4'(i);   // First cycle after reset is phase 0
      check_bit(cpu_enable, ph == `VCS_CPU_PHASE, $sformatf("cycle %0d cpu_enable_o", i));
      check_bit(tia_enable, ph >= `VCS_TIA_PHASE_LO && ph <= `VCS_TIA_PHASE_HI,
                $sformatf("cycle %0d tia_enable_o", i));
    end
    check_bit(cpu_rdy, 1'b1, "cpu_rdy_o after reset");
    check_bit(cpu_reset, 1'b0, "cpu_reset_o after reset");
    check_bit(pal, 1'b0, "pal_o after reset");
    report_test("phases", errs0);
  endtask

  task automatic test_rom_load();
    logic [11:0] a;
    int          errs0;
    errs0 = err_count;
    load_image(4096, 1'b1);
    check_scheme_pal(SCHEME_NONE, '0, "4 KiB image");
    for (int n = 0; n < 64; n++) begin
      a = 12'($random(seed));
      cpu_read_check(16'h1000 | 16'(a), rom_model[{3'd0, a}], "4 KiB ROM");
    end
    report_test("rom_load", errs0);
  endtask

  task automatic test_banks();
    bank_scheme_e schemes [3];
    logic [15:0]  base;
    logic [11:0]  a;
    int           n_banks;
    int           errs0;
    errs0 = err_count;
    schemes = '{SCHEME_F8, SCHEME_F6, SCHEME_F4};
    for (int s = 0; s < 3; s++) begin
      load_image(8192 << s, 1'b0);
      check_scheme_pal(schemes[s], '0, $sformatf("%0d KiB image", 8 << s));
      n_banks = 2 << s;
      base    = 16'h1FF8 - 16'(2 * s);   // 1FF8, 1FF6, 1FF4
      for (int b = n_banks - 1; b >= 0; b--) begin   // Descending, so each hit moves the bank
        hold_hotspot(base + 16'(b));
        for (int k = 0; k < 4; k++) begin
          a = 12'($random(seed)) & 12'hEFF;   // Stay clear of the hotspot page
          cpu_read_check(16'h1000 | 16'(a), rom_model[{3'(b), a}],
                         $sformatf("%s bank %0d", schemes[s].name(), b));
        end
      end
    end
    report_test("banks", errs0);
  endtask

  task automatic test_ram_selects();
    logic [7:0] data;
    int         errs0;
    errs0 = err_count;
    for (int i = 0; i < 128; i++) begin
      ram_model[i] = 8'($random(seed));
      cpu_write(16'h0080 + 16'(i), ram_model[i]);
    end
    for (int i = 0; i < 128; i++) cpu_read_check(16'h0080 + 16'(i), ram_model[i], "console RAM");
    for (int i = 0; i < 128; i++) begin
      host_ram_read(7'(i), data);
      check_byte(data, ram_model[i], $sformatf("host readback %02h", i));
    end
    cpu_read(16'h0000, data);   // TIA space
    check_byte(data, TIA_BYTE, "TIA data");
    check_bit(tia_cs, 1'b1, "tia_cs_o at 0000");
    check_bit(pia_cs, 1'b0, "pia_cs_o at 0000");
    cpu_read(16'h0280, data);   // PIA space
    check_byte(data, PIA_BYTE, "PIA data");
    check_bit(tia_cs, 1'b0, "tia_cs_o at 0280");
    check_bit(pia_cs, 1'b1, "pia_cs_o at 0280");
    report_test("ram_selects", errs0);
  endtask

  task automatic test_control();
    cart_ctrl_t  c;
    logic [11:0] a;
    int          errs0;
    errs0 = err_count;
    c = '0;
    c.pal = 1'b1;
    ctrl_write(c);
    check_scheme_pal(SCHEME_F4, c, "pal set");
    c = '0;
    c.load_hold = 1'b1;
    ctrl_write(c);
    check_scheme_pal(SCHEME_F4, c, "load hold");
    c = '0;
    c.soft_reset = 1'b1;
    ctrl_write(c);
    check_scheme_pal(SCHEME_F4, c, "soft reset");
    c = '0;
    c.cart_ram_en = 1'b1;
    ctrl_write(c);
    check_scheme_pal(SCHEME_F4, c, "cart RAM on");
    for (int i = 0; i < 128; i++) begin
      cart_model[i] = 8'($random(seed));
      cpu_write(16'h1000 + 16'(i), cart_model[i]);
    end
    for (int i = 0; i < 128; i++) cpu_read_check(16'h1000 + 16'(i), cart_model[i], "cart RAM");

    // Move to bank 5, then soft reset must drop it back to 0
    hold_hotspot(16'h1FF9);
    a = 12'h200 | 12'($random(seed) & 8'hFF);
    cpu_read_check(16'h1000 | 16'(a), rom_model[{3'd5, a}], "F4 bank 5");
    c = '0;
    c.soft_reset = 1'b1;
    ctrl_write(c);
    ctrl_write('0);
    check_scheme_pal(SCHEME_F4, '0, "control cleared");
    for (int i = 0; i < 128; i++) begin
      cpu_read_check(16'h1000 + 16'(i), rom_model[{3'd0, 12'(i)}], "ROM after soft reset");
    end
    report_test("control", errs0);
  endtask

  // ==============================
  // Sequence
  // ==============================
  initial begin
    pwr_up_reset_n = 1'b1;
    cpu            = IDLE_BUS;
    host           = '0;
    tia_dat        = TIA_BYTE;
    pia_dat        = PIA_BYTE;
    repeat (2) @(posedge clk_sys);
    pwr_up_reset_n <= 1'b0;
    test_phases();
    test_rom_load();
    test_banks();
    test_ram_selects();
    test_control();
    prop_fails = vcs_mem_top_i.bus_ctrl_i.props_i.fail_count;
    $display("Summary: %0d checks, %0d value errors, %0d assertion failures",
             check_count, err_count, prop_fails);
    if (err_count == 0 && prop_fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/vcs_mem_properties.sv */
`default_nettype none
`timescale 1ns/1ps

module vcs_mem_properties import vcs_pkg::*; (
  input wire        clk_sys,
  input wire        pwr_up_reset_n,
  input wire        cpu_enable_i,
  input wire        tia_enable_i,
  input wire        tia_cs_i,
  input wire        pia_cs_i,
  input wire        cpu_rdy_i,
  input cart_ctrl_t ctrl_i
);

  int fail_count = 0;   // Failed assertion tally

  // CPU strobe and video window never overlap
  a_enable_excl: assert property (@(posedge clk_sys) disable iff (pwr_up_reset_n)
    !(cpu_enable_i && tia_enable_i))
    else begin
      $error("cpu_enable_o and tia_enable_o high in the same cycle");
      fail_count++;
    end

  a_cs_onehot: assert property (@(posedge clk_sys) disable iff (pwr_up_reset_n)
    !(tia_cs_i && pia_cs_i))   // TIA and PIA decode are disjoint
    else begin
      $error("tia_cs_o and pia_cs_o both high");
      fail_count++;
    end

  // Ready is just the inverted hold bit
  a_rdy_hold: assert property (@(posedge clk_sys) disable iff (pwr_up_reset_n)
    cpu_rdy_i == !ctrl_i.load_hold)
    else begin
      $error("cpu_rdy_o does not follow load_hold");
      fail_count++;
    end

endmodule

bind vcs_bus_ctrl vcs_mem_properties props_i (
  .clk_sys        (clk_sys),
  .pwr_up_reset_n (pwr_up_reset_n),
  .cpu_enable_i   (cpu_enable_o),
  .tia_enable_i   (tia_enable_o),
  .tia_cs_i       (tia_cs_o),
  .pia_cs_i       (pia_cs_o),
  .cpu_rdy_i      (cpu_rdy_o),
  .ctrl_i         (ctrl_i)
);

`default_nettype wire

/* hdl/vcs_mem_top.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_mem_top import vcs_pkg::*; (
  input  wire        clk_sys,
  input  wire        pwr_up_reset_n,
  input  cpu_bus_t   cpu_i,
  input  host_req_t  host_i,
  input  wire  [7:0] tia_dat_i,
  input  wire  [7:0] pia_dat_i,
  output logic [7:0] cpu_din_o,
  output logic [7:0] host_rdata_o,
  output logic       tia_cs_o,
  output logic       pia_cs_o,
  output logic       cpu_enable_o,
  output logic       tia_enable_o,
  output logic       cpu_reset_o,
  output logic       cpu_rdy_o,
  output logic       pal_o
);

  // ==============================
  // Interconnect
  // ==============================
  logic                    rom_we;
  logic [`VCS_ROM_AW-1:0]  rom_waddr;
  logic [7:0]              rom_wdata;
  logic [`VCS_ROM_AW-1:0]  rom_raddr;
  logic [7:0]              rom_rdata;
  logic                    host_ram_rd;
  bank_scheme_e            scheme;
  cart_ctrl_t              ctrl;
  logic [`VCS_RAM_AW-1:0]  ram_addr;
  logic                    ram_we;
  logic [7:0]              ram_rdata;
  logic [`VCS_RAM_AW-1:0]  cart_addr;
  logic                    cart_we;
  logic [7:0]              cart_rdata;

  assign host_rdata_o = ram_rdata;   // Console RAM readback
  assign pal_o        = ctrl.pal;

  vcs_host_loader loader_i (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .host_i         (host_i),
    .rom_we_o       (rom_we),
    .rom_waddr_o    (rom_waddr),
    .rom_wdata_o    (rom_wdata),
    .host_ram_rd_o  (host_ram_rd),
    .scheme_o       (scheme),
    .ctrl_o         (ctrl)
  );

  vcs_bus_ctrl bus_ctrl_i (
    .clk_sys        (clk_sys),
    .pwr_up_reset_n (pwr_up_reset_n),
    .cpu_i          (cpu_i),
    .scheme_i       (scheme),
    .ctrl_i         (ctrl),
    .host_ram_rd_i  (host_ram_rd),
    .host_addr_i    (host_i.addr[`VCS_RAM_AW-1:0]),
    .rom_rdata_i    (rom_rdata),
    .ram_rdata_i    (ram_rdata),
    .cart_rdata_i   (cart_rdata),
    .tia_dat_i      (tia_dat_i),
    .pia_dat_i      (pia_dat_i),
    .rom_raddr_o    (rom_raddr),
    .ram_addr_o     (ram_addr),
    .ram_we_o       (ram_we),
    .cart_addr_o    (cart_addr),
    .cart_we_o      (cart_we),
    .cpu_din_o      (cpu_din_o),
    .tia_cs_o       (tia_cs_o),
    .pia_cs_o       (pia_cs_o),
    .cpu_enable_o   (cpu_enable_o),
    .tia_enable_o   (tia_enable_o),
    .cpu_reset_o    (cpu_reset_o),
    .cpu_rdy_o      (cpu_rdy_o)
  );

  // ==============================
  // Memories
  // ==============================
  vcs_cart_rom cart_rom_i (
    .clk_sys (clk_sys),
    .we_i    (rom_we),
    .waddr_i (rom_waddr),
    .wdata_i (rom_wdata),
    .raddr_i (rom_raddr),
    .rdata_o (rom_rdata)
  );

  vcs_ram ram_i (          // Console RAM at 0x0080
    .clk_sys (clk_sys),
    .addr_i  (ram_addr),
    .we_i    (ram_we),
    .wdata_i (cpu_i.wdata),
    .rdata_o (ram_rdata)
  );

  vcs_ram cart_ram_i (     // Cartridge RAM at 0x1000
    .clk_sys (clk_sys),
    .addr_i  (cart_addr),
    .we_i    (cart_we),
    .wdata_i (cpu_i.wdata),
    .rdata_o (cart_rdata)
  );

endmodule

`default_nettype wire

/* hdl/vcs_ram.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_ram #(
  parameter int DEPTH = 1 << `VCS_RAM_AW
) (
  input  wire                      clk_sys,
  input  wire  [`VCS_RAM_AW-1:0]   addr_i,
  input  wire                      we_i,
  input  wire  [7:0]               wdata_i,
  output logic [7:0]               rdata_o
);

  logic [7:0] mem [DEPTH];

  // Single port, read returns old contents on a write
  always_ff @(posedge clk_sys) begin
    rdata_o <= mem[addr_i];
    if (we_i) begin
      mem[addr_i] <= wdata_i;   // Visible on next read
    end
  end

endmodule

`default_nettype wire

/* hdl/vcs_cart_rom.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_cart_rom (
  input  wire                      clk_sys,
  input  wire                      we_i,
  input  wire  [`VCS_ROM_AW-1:0]   waddr_i,
  input  wire  [7:0]               wdata_i,
  input  wire  [`VCS_ROM_AW-1:0]   raddr_i,
  output logic [7:0]               rdata_o
);

  localparam int ROM_DEPTH = 1 << `VCS_ROM_AW;   // 32 KiB

  logic [7:0] mem [ROM_DEPTH];

  // ==============================
  // Host load port
  // ==============================
  always_ff @(posedge clk_sys) begin
    if (we_i) mem[waddr_i] <= wdata_i;
  end

  // ==============================
  // CPU read port
  // ==============================
  // Registered, matches select pipeline in controller
  always_ff @(posedge clk_sys) begin
    rdata_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

/* hdl/vcs_bus_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_bus_ctrl import vcs_pkg::*; (
  input  wire                      clk_sys,
  input  wire                      pwr_up_reset_n,
  input  cpu_bus_t                 cpu_i,
  input  bank_scheme_e             scheme_i,
  input  cart_ctrl_t               ctrl_i,
  input  wire                      host_ram_rd_i,
  input  wire  [`VCS_RAM_AW-1:0]   host_addr_i,
  input  wire  [7:0]               rom_rdata_i,
  input  wire  [7:0]               ram_rdata_i,
  input  wire  [7:0]               cart_rdata_i,
  input  wire  [7:0]               tia_dat_i,
  input  wire  [7:0]               pia_dat_i,
  output logic [`VCS_ROM_AW-1:0]   rom_raddr_o,
  output logic [`VCS_RAM_AW-1:0]   ram_addr_o,
  output logic                     ram_we_o,
  output logic [`VCS_RAM_AW-1:0]   cart_addr_o,
  output logic                     cart_we_o,
  output logic [7:0]               cpu_din_o,
  output logic                     tia_cs_o,
  output logic                     pia_cs_o,
  output logic                     cpu_enable_o,
  output logic                     tia_enable_o,
  output logic                     cpu_reset_o,
  output logic                     cpu_rdy_o
);

  localparam logic [`VCS_PHASE_BITS-1:0] CPU_PH  = `VCS_CPU_PHASE;
  localparam logic [`VCS_PHASE_BITS-1:0] TIA_LO  = `VCS_TIA_PHASE_LO;
  localparam logic [`VCS_PHASE_BITS-1:0] TIA_HI  = `VCS_TIA_PHASE_HI;
  localparam logic [`VCS_PHASE_BITS-1:0] BANK_PH = `VCS_BANK_PHASE;

  logic [`VCS_PHASE_BITS-1:0] phase_q;
  logic [2:0]                 bank_q;
  logic [2:0]                 bank_d;
  logic                       bank_hit;
  logic [12:0]                a13;      // Cartridge sees 13 address lines
  bus_sel_e                   sel_d;
  bus_sel_e                   sel_q;    // Aligned with memory read latency

  assign a13 = cpu_i.addr[12:0];

  // ==============================
  // Phases and CPU control
  // ==============================
  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) phase_q <= '0;
    else                phase_q <= phase_q + 1'b1;   // Wraps after 16
  end

  assign cpu_enable_o = phase_q == CPU_PH;
  assign tia_enable_o = phase_q >= TIA_LO && phase_q <= TIA_HI;
  assign cpu_reset_o  = pwr_up_reset_n || ctrl_i.soft_reset;
  assign cpu_rdy_o    = !ctrl_i.load_hold;       // CPU stalls during load

  // ==============================
  // Address decode
  // ==============================
  always_comb begin
    sel_d = SEL_NONE;
    if (!a13[12] && !a13[7])      sel_d = SEL_TIA;
    else if (!a13[12] && a13[9])  sel_d = SEL_PIA;
    else if (!a13[12])            sel_d = SEL_RAM;
    else if (ctrl_i.cart_ram_en && a13[11:8] == 4'h0)
                                  sel_d = SEL_CART_RAM;   // Overrides ROM low page
    else                          sel_d = SEL_ROM;
  end

  assign tia_cs_o = sel_d == SEL_TIA;
  assign pia_cs_o = sel_d == SEL_PIA;

  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) sel_q <= SEL_NONE;
    else                sel_q <= sel_d;
  end

  // ==============================
  // Bank switching
  // ==============================
  always_comb begin
    bank_hit = 1'b0;
    bank_d   = bank_q;
    unique case (scheme_i)
      SCHEME_F8: if (a13 >= 13'h1FF8 && a13 <= 13'h1FF9) begin
        bank_hit = 1'b1;
        bank_d   = 3'(a13 - 13'h1FF8);
      end
      SCHEME_F6: if (a13 >= 13'h1FF6 && a13 <= 13'h1FF9) begin
        bank_hit = 1'b1;
        bank_d   = 3'(a13 - 13'h1FF6);
      end
      SCHEME_F4: if (a13 >= 13'h1FF4 && a13 <= 13'h1FFB) begin
        bank_hit = 1'b1;
        bank_d   = 3'(a13 - 13'h1FF4);
      end
      default: bank_hit = 1'b0;   // No hotspots, bank stays 0
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (cpu_reset_o) bank_q <= '0;                          // Soft reset too
    else if (phase_q == BANK_PH && bank_hit) bank_q <= bank_d;
  end

  // ==============================
  // Memory addressing
  // ==============================
  assign rom_raddr_o = {bank_q, a13[11:0]};
  assign ram_addr_o  = host_ram_rd_i ? host_addr_i : a13[`VCS_RAM_AW-1:0];   // Host wins
  assign ram_we_o    = !cpu_i.rnw && sel_d == SEL_RAM && !host_ram_rd_i;
  assign cart_addr_o = a13[`VCS_RAM_AW-1:0];
  assign cart_we_o   = !cpu_i.rnw && sel_d == SEL_CART_RAM;

  // Read mux, one cycle behind address
  always_comb begin
    unique case (sel_q)
      SEL_TIA:      cpu_din_o = tia_dat_i;
      SEL_PIA:      cpu_din_o = pia_dat_i;
      SEL_RAM:      cpu_din_o = ram_rdata_i;
      SEL_CART_RAM: cpu_din_o = cart_rdata_i;
      SEL_ROM:      cpu_din_o = rom_rdata_i;
      default:      cpu_din_o = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/vcs_host_loader.sv */
`default_nettype none
`timescale 1ns/1ps

`include "vcs_cfg.svh"

module vcs_host_loader import vcs_pkg::*; (
  input  wire                      clk_sys,
  input  wire                      pwr_up_reset_n,
  input  host_req_t                host_i,
  output logic                     rom_we_o,
  output logic [`VCS_ROM_AW-1:0]   rom_waddr_o,
  output logic [7:0]               rom_wdata_o,
  output logic                     host_ram_rd_o,
  output bank_scheme_e             scheme_o,
  output cart_ctrl_t               ctrl_o
);

  logic [7:0] region;
  logic       rom_region;
  logic       ctrl_region;
  logic [2:0] size_q;     // Image size flags, 4K/8K/16K steps

  assign region      = host_i.addr[`VCS_HOST_AW-1 -: 8];
  assign rom_region  = region == `VCS_REGION_ROM;
  assign ctrl_region = region == `VCS_REGION_CTRL;

  // ==============================
  // ROM load path
  // ==============================
  assign rom_we_o      = host_i.wr && rom_region;   // Lands on next edge
  assign rom_waddr_o   = host_i.addr[`VCS_ROM_AW-1:0];
  assign rom_wdata_o   = host_i.wdata;
  assign host_ram_rd_o = host_i.rd && rom_region;   // RAM readback shares region

  // Size tracks highest address bits seen, kept over reset
  always_ff @(posedge clk_sys) begin
    if (rom_we_o) begin
      if (rom_waddr_o == '0) size_q <= 3'b000;      // New image starts
      if (rom_waddr_o[12])   size_q[0] <= 1'b1;
      if (rom_waddr_o[13])   size_q[1] <= 1'b1;
      if (rom_waddr_o[14])   size_q[2] <= 1'b1;
    end
  end

  always_comb begin
    unique case (size_q)
      3'b001:  scheme_o = SCHEME_F8;
      3'b011:  scheme_o = SCHEME_F6;
      3'b111:  scheme_o = SCHEME_F4;
      default: scheme_o = SCHEME_NONE;   // 2K/4K or odd sizes
    endcase
  end

  // ==============================
  // Control register
  // ==============================
  always_ff @(posedge clk_sys) begin
    if (pwr_up_reset_n) ctrl_o <= '0;
    else if (host_i.wr && ctrl_region) ctrl_o <= cart_ctrl_t'(host_i.wdata[3:0]);
  end

endmodule

`default_nettype wire

/* hdl/vcs_pkg.sv */
`default_nettype none

`include "vcs_cfg.svh"

package vcs_pkg;

  // Bank switching scheme, chosen from image size
  typedef enum logic [1:0] {
    SCHEME_NONE,
    SCHEME_F8,    // 8 KiB, two banks
    SCHEME_F6,    // 16 KiB, four banks
    SCHEME_F4     // 32 KiB, eight banks
  } bank_scheme_e;

  // Chip select for the read mux
  typedef enum logic [2:0] {
    SEL_NONE,
    SEL_TIA,
    SEL_PIA,
    SEL_RAM,
    SEL_CART_RAM,
    SEL_ROM
  } bus_sel_e;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        rnw;     // High on read
  } cpu_bus_t;

  typedef struct packed {
    logic                    wr;
    logic                    rd;
    logic [`VCS_HOST_AW-1:0] addr;   // Region in top byte
    logic [7:0]              wdata;
  } host_req_t;

  // Bit order matches the control byte, soft_reset is bit 0
  typedef struct packed {
    logic pal;
    logic cart_ram_en;
    logic load_hold;
    logic soft_reset;
  } cart_ctrl_t;

endpackage

`default_nettype wire

/* hdl/vcs_cfg.svh */
`ifndef VCS_CFG_SVH
`define VCS_CFG_SVH

// ==============================
// Clock enable phases
// ==============================
`define VCS_PHASE_BITS   4      // 16-step phase counter
`define VCS_CPU_PHASE    0      // CPU enable strobe
`define VCS_TIA_PHASE_LO 5      // Video enable window start
`define VCS_TIA_PHASE_HI 7      // Video enable window end
`define VCS_BANK_PHASE   15     // Hotspot sampling phase

// ==============================
// Memory and host widths
// ==============================
`define VCS_ROM_AW       15     // 32 KiB cartridge image
`define VCS_RAM_AW       7      // 128 bytes
`define VCS_HOST_AW      32
`define VCS_REGION_ROM   8'h00  // ROM load and RAM readback
`define VCS_REGION_CTRL  8'hFF  // Control register

`endif
